//--- design/icache_pkg.sv
package icache_pkg;

    // Message and access operation codes
    localparam logic [2:0] OP_NOP  = 3'd0;
    localparam logic [2:0] OP_LD   = 3'd1;  // Pipeline fetch
    localparam logic [2:0] OP_FILL = 3'd2;  // Reply line from memory
    localparam logic [2:0] OP_RD   = 3'd3;  // Miss request to memory
    localparam logic [2:0] OP_INV  = 3'd5;  // Coherence invalidation

    // Bank geometry
    localparam int CL_SIZE     = 128;
    localparam int OFFSET_BITS = 4;
    localparam int IDX_BITS    = 4;  // 16 lines per bank
    localparam int TAG_BITS    = 24;

    // One address word, read either raw or split for the array lookup
    typedef union packed {
        logic [31:0] raw;
        struct packed {
            logic [TAG_BITS-1:0]    tag;
            logic [IDX_BITS-1:0]    idx;
            logic [OFFSET_BITS-1:0] offset;
        } f;
    } cache_addr_u;

endpackage

//--- design/msg_fifo.sv
`timescale 1ns/100ps

module msg_fifo #(
    parameter int Q_LENGTH = 8,
    parameter int WIDTH    = 32
) (
    input  logic             clk,
    input  logic             arst_n,
    input  logic             alloc,
    input  logic [WIDTH-1:0] msg_in,
    input  logic             dealloc,
    output logic             full,
    output logic             valid,
    output logic [WIDTH-1:0] msg_out
);
    localparam int PTR_W = (Q_LENGTH > 1) ? $clog2(Q_LENGTH) : 1;
    localparam int CNT_W = $clog2(Q_LENGTH + 1);

    logic [WIDTH-1:0] mem [Q_LENGTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             push;
    logic             pop;

    assign full    = (count == CNT_W'(Q_LENGTH));
    assign valid   = (count != '0);
    assign msg_out = mem[rd_ptr];   // Head of queue
    assign push    = alloc && !full; // Push into a full queue is lost
    assign pop     = dealloc && valid;

    always_ff @(posedge clk) begin
        if (push) mem[wr_ptr] <= msg_in;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) wr_ptr <= (wr_ptr == PTR_W'(Q_LENGTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (pop) rd_ptr <= (rd_ptr == PTR_W'(Q_LENGTH - 1)) ? '0 : rd_ptr + 1'b1;
            if (push && !pop) count <= count + 1'b1;
            else if (pop && !push) count <= count - 1'b1;
        end
    end

endmodule

//--- design/queue_arbitrator.sv
`timescale 1ns/100ps

module queue_arbitrator (
    input  logic                           fill_valid,
    input  logic [31:0]                    fill_addr,
    input  logic [icache_pkg::CL_SIZE-1:0] fill_line,
    input  logic                           inv_valid,
    input  logic [31:0]                    inv_addr,
    input  logic [31:0]                    fetch_addr,
    input  logic                           stall,
    output logic                           acc_valid,
    output logic [2:0]                     acc_op,
    output logic [31:0]                    acc_addr,
    output logic [icache_pkg::CL_SIZE-1:0] acc_line,
    output logic                           fill_dealloc,
    output logic                           inv_dealloc
);

    // Fills first so a blocked bank can always make progress
    always_comb begin
        acc_valid    = 1'b0;
        acc_op       = icache_pkg::OP_NOP;
        acc_addr     = fetch_addr;
        acc_line     = '0;
        fill_dealloc = 1'b0;
        inv_dealloc  = 1'b0;

        if (fill_valid) begin
            acc_valid    = 1'b1;
            acc_op       = icache_pkg::OP_FILL;
            acc_addr     = fill_addr;
            acc_line     = fill_line;
            fill_dealloc = 1'b1;  // Pop at the coming edge
        end else if (inv_valid) begin
            acc_valid   = 1'b1;
            acc_op      = icache_pkg::OP_INV;
            acc_addr    = inv_addr;
            inv_dealloc = 1'b1;
        end else if (!stall) begin
            // Fetch only while no miss is outstanding
            acc_valid = 1'b1;
            acc_op    = icache_pkg::OP_LD;
        end
    end

endmodule

//--- design/cache_bank.sv
`timescale 1ns/100ps

module cache_bank (
    input  logic                           clk,
    input  logic                           arst_n,
    input  logic                           acc_valid,
    input  logic [2:0]                     acc_op,
    input  logic [31:0]                    acc_addr,
    input  logic [icache_pkg::CL_SIZE-1:0] acc_line,
    input  logic                           full_miss,
    output logic [31:0]                    addr_out,
    output logic [icache_pkg::CL_SIZE-1:0] cl,
    output logic                           hit,
    output logic                           is_write,
    output logic [31:0]                    addr_miss,
    output logic [2:0]                     op_miss,
    output logic                           alloc_miss,
    output logic                           stall
);
    localparam int LINES = 1 << icache_pkg::IDX_BITS;

    icache_pkg::cache_addr_u acc_u;
    icache_pkg::cache_addr_u miss_u;  // Line of the outstanding miss

    logic [icache_pkg::TAG_BITS-1:0] tag_mem  [LINES];
    logic [icache_pkg::CL_SIZE-1:0]  data_mem [LINES];
    logic [LINES-1:0]                valid_q;

    logic tag_match;
    logic do_fetch;
    logic do_fill;
    logic do_inv;
    logic fetch_miss;
    logic fill_done;
    logic req_pending;  // Miss waiting for memory to accept it

    assign acc_u.raw = acc_addr;

    assign tag_match = valid_q[acc_u.f.idx] && (tag_mem[acc_u.f.idx] == acc_u.f.tag);

    assign do_fetch   = acc_valid && (acc_op == icache_pkg::OP_LD);
    assign do_fill    = acc_valid && (acc_op == icache_pkg::OP_FILL);
    assign do_inv     = acc_valid && (acc_op == icache_pkg::OP_INV);
    assign fetch_miss = do_fetch && !tag_match;

    // Only the reply for the missing line releases the bank
    assign fill_done = do_fill && stall &&
                       (acc_u.f.tag == miss_u.f.tag) && (acc_u.f.idx == miss_u.f.idx);

    assign addr_miss = miss_u.raw;
    assign op_miss   = alloc_miss ? icache_pkg::OP_RD : icache_pkg::OP_NOP;

    // Arrays and result payload
    always_ff @(posedge clk) begin
        if (acc_valid) begin
            addr_out <= acc_addr;
            cl       <= do_fill ? acc_line : data_mem[acc_u.f.idx];
        end
        if (do_fill) begin
            tag_mem[acc_u.f.idx]  <= acc_u.f.tag;
            data_mem[acc_u.f.idx] <= acc_line;
        end
        if (fetch_miss) begin
            miss_u.raw <= {acc_u.f.tag, acc_u.f.idx, {icache_pkg::OFFSET_BITS{1'b0}}};
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q     <= '0;
            hit         <= 1'b0;
            is_write    <= 1'b0;
            stall       <= 1'b0;
            req_pending <= 1'b0;
            alloc_miss  <= 1'b0;
        end else begin
            hit        <= do_fetch && tag_match;
            is_write   <= do_fill || do_inv;  // Write results carry no fetch data
            alloc_miss <= 1'b0;

            if (do_fill) begin
                valid_q[acc_u.f.idx] <= 1'b1;
            end else if (do_inv && tag_match) begin
                valid_q[acc_u.f.idx] <= 1'b0;
            end

            if (fetch_miss) begin
                stall <= 1'b1;
                if (full_miss) req_pending <= 1'b1;  // Memory busy, hold it
                else alloc_miss <= 1'b1;
            end else if (req_pending && !full_miss) begin
                req_pending <= 1'b0;
                alloc_miss  <= 1'b1;
            end

            if (fill_done) stall <= 1'b0;
        end
    end

endmodule

//--- design/icache_top.sv
`timescale 1ns/100ps

module icache_top #(
    parameter int Q_LENGTH = 8
) (
    input  logic                           clk,
    input  logic                           arst_n,
    input  logic [31:0]                    addr_even,
    input  logic [31:0]                    addr_odd,
    input  logic                           alloc_fill_even,
    input  logic [31:0]                    addr_fill_even,
    input  logic [icache_pkg::CL_SIZE-1:0] line_fill_even,
    input  logic                           alloc_fill_odd,
    input  logic [31:0]                    addr_fill_odd,
    input  logic [icache_pkg::CL_SIZE-1:0] line_fill_odd,
    input  logic                           alloc_inv_even,
    input  logic [31:0]                    addr_inv_even,
    input  logic                           alloc_inv_odd,
    input  logic [31:0]                    addr_inv_odd,
    input  logic                           full_miss_even,
    input  logic                           full_miss_odd,
    output logic                           hit_even,
    output logic                           hit_odd,
    output logic [icache_pkg::CL_SIZE-1:0] cl_even,
    output logic [icache_pkg::CL_SIZE-1:0] cl_odd,
    output logic [31:0]                    addr_out_even,
    output logic [31:0]                    addr_out_odd,
    output logic                           is_write_even,
    output logic                           is_write_odd,
    output logic                           full_fill_even,
    output logic                           full_fill_odd,
    output logic                           full_inv_even,
    output logic                           full_inv_odd,
    output logic [31:0]                    addr_miss_even,
    output logic [31:0]                    addr_miss_odd,
    output logic [2:0]                     op_miss_even,
    output logic [2:0]                     op_miss_odd,
    output logic                           alloc_miss_even,
    output logic                           alloc_miss_odd,
    output logic                           stall
);
    localparam int FILL_W = 32 + icache_pkg::CL_SIZE;  // Address and line

    // Queue heads
    logic                           fq_valid_even, fq_valid_odd;
    logic [31:0]                    fq_addr_even, fq_addr_odd;
    logic [icache_pkg::CL_SIZE-1:0] fq_line_even, fq_line_odd;
    logic                           fq_pop_even, fq_pop_odd;
    logic                           iq_valid_even, iq_valid_odd;
    logic [31:0]                    iq_addr_even, iq_addr_odd;
    logic                           iq_pop_even, iq_pop_odd;

    // Selected access into each bank
    logic                           acc_valid_even, acc_valid_odd;
    logic [2:0]                     acc_op_even, acc_op_odd;
    logic [31:0]                    acc_addr_even, acc_addr_odd;
    logic [icache_pkg::CL_SIZE-1:0] acc_line_even, acc_line_odd;
    logic                           stall_even, stall_odd;

    assign stall = stall_even || stall_odd;

    msg_fifo #(.Q_LENGTH(Q_LENGTH), .WIDTH(FILL_W)) fill_q_even (
        .clk(clk), .arst_n(arst_n),
        .alloc(alloc_fill_even), .msg_in({addr_fill_even, line_fill_even}),
        .dealloc(fq_pop_even), .full(full_fill_even), .valid(fq_valid_even),
        .msg_out({fq_addr_even, fq_line_even})
    );

    msg_fifo #(.Q_LENGTH(Q_LENGTH), .WIDTH(32)) inv_q_even (
        .clk(clk), .arst_n(arst_n),
        .alloc(alloc_inv_even), .msg_in(addr_inv_even),
        .dealloc(iq_pop_even), .full(full_inv_even), .valid(iq_valid_even),
        .msg_out(iq_addr_even)
    );

    queue_arbitrator queue_arb_even (
        .fill_valid(fq_valid_even), .fill_addr(fq_addr_even), .fill_line(fq_line_even),
        .inv_valid(iq_valid_even), .inv_addr(iq_addr_even),
        .fetch_addr(addr_even), .stall(stall_even),
        .acc_valid(acc_valid_even), .acc_op(acc_op_even),
        .acc_addr(acc_addr_even), .acc_line(acc_line_even),
        .fill_dealloc(fq_pop_even), .inv_dealloc(iq_pop_even)
    );

    cache_bank cache_bank_even (
        .clk(clk), .arst_n(arst_n),
        .acc_valid(acc_valid_even), .acc_op(acc_op_even),
        .acc_addr(acc_addr_even), .acc_line(acc_line_even),
        .full_miss(full_miss_even),
        .addr_out(addr_out_even), .cl(cl_even), .hit(hit_even), .is_write(is_write_even),
        .addr_miss(addr_miss_even), .op_miss(op_miss_even),
        .alloc_miss(alloc_miss_even), .stall(stall_even)
    );

    msg_fifo #(.Q_LENGTH(Q_LENGTH), .WIDTH(FILL_W)) fill_q_odd (
        .clk(clk), .arst_n(arst_n),
        .alloc(alloc_fill_odd), .msg_in({addr_fill_odd, line_fill_odd}),
        .dealloc(fq_pop_odd), .full(full_fill_odd), .valid(fq_valid_odd),
        .msg_out({fq_addr_odd, fq_line_odd})
    );

    msg_fifo #(.Q_LENGTH(Q_LENGTH), .WIDTH(32)) inv_q_odd (
        .clk(clk), .arst_n(arst_n),
        .alloc(alloc_inv_odd), .msg_in(addr_inv_odd),
        .dealloc(iq_pop_odd), .full(full_inv_odd), .valid(iq_valid_odd),
        .msg_out(iq_addr_odd)
    );

    queue_arbitrator queue_arb_odd (
        .fill_valid(fq_valid_odd), .fill_addr(fq_addr_odd), .fill_line(fq_line_odd),
        .inv_valid(iq_valid_odd), .inv_addr(iq_addr_odd),
        .fetch_addr(addr_odd), .stall(stall_odd),
        .acc_valid(acc_valid_odd), .acc_op(acc_op_odd),
        .acc_addr(acc_addr_odd), .acc_line(acc_line_odd),
        .fill_dealloc(fq_pop_odd), .inv_dealloc(iq_pop_odd)
    );

    cache_bank cache_bank_odd (
        .clk(clk), .arst_n(arst_n),
        .acc_valid(acc_valid_odd), .acc_op(acc_op_odd),
        .acc_addr(acc_addr_odd), .acc_line(acc_line_odd),
        .full_miss(full_miss_odd),
        .addr_out(addr_out_odd), .cl(cl_odd), .hit(hit_odd), .is_write(is_write_odd),
        .addr_miss(addr_miss_odd), .op_miss(op_miss_odd),
        .alloc_miss(alloc_miss_odd), .stall(stall_odd)
    );

endmodule

//--- tests/tb_clock.sv
`timescale 1ns/100ps

module tb_clock (
    output logic clk,
    output logic arst_n
);
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;  // 4 ns period
    end

    initial begin
        arst_n = 1'b0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;  // Release away from the active edge
    end

endmodule

//--- tests/icache_tb.sv
`timescale 1ns/100ps

module icache_tb;
    localparam int          Q_LENGTH = 8;
    localparam int          MAX_REC  = 64;
    localparam logic [31:0] PARK     = 32'h0000_f000;  // Idle fetch line, index 0

    logic clk, arst_n;
    logic [31:0] addr_r [2], fill_addr_r [2], inv_addr_r [2];
    logic [127:0] fill_line_r [2];
    logic fill_alloc_r [2], inv_alloc_r [2], fmiss_r [2];
    logic hit_w [2], isw_w [2], ffill_w [2], finv_w [2], allocm_w [2];
    logic [127:0] cl_w [2];
    logic [31:0] aout_w [2], amiss_w [2];
    logic [2:0] opmiss_w [2];
    logic stall;

    // Reference model of each bank
    logic m_valid [2][16];
    logic [23:0] m_tag [2][16];
    logic [127:0] m_line [2][16];
    logic stalled [2];
    logic [31:0] miss_line [2];

    int miss_cnt [2];
    logic [31:0] last_miss_addr [2];
    logic [2:0] last_miss_op [2];
    logic [159:0] wq0 [$];  // Write results seen, address and line
    logic [159:0] wq1 [$];

    int rec_test [MAX_REC], rec_bank [MAX_REC];
    string rec_act [MAX_REC];
    logic [31:0] rec_addr [MAX_REC], rec_word [MAX_REC];
    int n_rec = 0, errors = 0, test_err = 0, checks = 0, tests_done = 0;
    int cycles = 0, limit = 0, cur_test = 1;
    integer seed = 32'h37630238;

    tb_clock clock_i (.clk(clk), .arst_n(arst_n));

    icache_top #(.Q_LENGTH(Q_LENGTH)) dut_i (
        .clk(clk), .arst_n(arst_n), .addr_even(addr_r[0]), .addr_odd(addr_r[1]),
        .alloc_fill_even(fill_alloc_r[0]), .addr_fill_even(fill_addr_r[0]),
        .line_fill_even(fill_line_r[0]), .alloc_fill_odd(fill_alloc_r[1]),
        .addr_fill_odd(fill_addr_r[1]), .line_fill_odd(fill_line_r[1]),
        .alloc_inv_even(inv_alloc_r[0]), .addr_inv_even(inv_addr_r[0]),
        .alloc_inv_odd(inv_alloc_r[1]), .addr_inv_odd(inv_addr_r[1]),
        .full_miss_even(fmiss_r[0]), .full_miss_odd(fmiss_r[1]),
        .hit_even(hit_w[0]), .hit_odd(hit_w[1]), .cl_even(cl_w[0]), .cl_odd(cl_w[1]),
        .addr_out_even(aout_w[0]), .addr_out_odd(aout_w[1]),
        .is_write_even(isw_w[0]), .is_write_odd(isw_w[1]),
        .full_fill_even(ffill_w[0]), .full_fill_odd(ffill_w[1]),
        .full_inv_even(finv_w[0]), .full_inv_odd(finv_w[1]),
        .addr_miss_even(amiss_w[0]), .addr_miss_odd(amiss_w[1]),
        .op_miss_even(opmiss_w[0]), .op_miss_odd(opmiss_w[1]),
        .alloc_miss_even(allocm_w[0]), .alloc_miss_odd(allocm_w[1]), .stall(stall)
    );

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (limit > 0 && cycles >= limit) begin
            $display("timeout: run did not finish within %0d cycles", limit);
            $display("=== FAIL ===");
            $finish;
        end
    end

    // Outputs sampled mid-cycle
    always @(negedge clk) begin
        for (int b = 0; b < 2; b++) begin
            if (arst_n && allocm_w[b]) begin
                miss_cnt[b] = miss_cnt[b] + 1;
                last_miss_addr[b] = amiss_w[b];
                last_miss_op[b] = opmiss_w[b];
            end
        end
        if (arst_n && isw_w[0]) wq0.push_back({aout_w[0], cl_w[0]});
        if (arst_n && isw_w[1]) wq1.push_back({aout_w[1], cl_w[1]});
    end

    function automatic string sig(string name, int b);
        if (b == 0) return {name, "_even"};
        return {name, "_odd"};
    endfunction

    function automatic logic [127:0] build_line(logic [31:0] w);
        if (w == 0) return {$random(seed), $random(seed), $random(seed), $random(seed)};
        return {4{w}};
    endfunction

    task automatic check_value(string name, logic [127:0] exp, logic [127:0] act);
        checks++;
        if (exp !== act) begin
            $display("mismatch at %0t: %s expected %h got %h", $time, name, exp, act);
            errors++;
            test_err++;
        end
    endtask

    task automatic pop_write(int b, output logic [159:0] got);
        while (((b == 0) ? wq0.size() : wq1.size()) == 0) @(negedge clk);
        if (b == 0) got = wq0.pop_front();
        else got = wq1.pop_front();
    endtask

    task automatic wait_stall();
        while (stall !== (stalled[0] || stalled[1])) @(negedge clk);
    endtask

    // Fetch result is due one cycle after the fetch is taken
    task automatic wait_fetch_result(int b, logic [31:0] a);
        repeat (2) @(negedge clk);
        check_value(sig("addr_out", b), 128'(a), 128'(aout_w[b]));
        check_value(sig("is_write", b), 128'(0), 128'(isw_w[b]));
    endtask

    task automatic record_write(int b, logic [31:0] a, logic [127:0] line);
        m_valid[b][a[7:4]] = 1'b1;
        m_tag[b][a[7:4]] = a[31:8];
        m_line[b][a[7:4]] = line;
        if (stalled[b] && miss_line[b] == {a[31:4], 4'h0}) stalled[b] = 1'b0;
    endtask

    task automatic fetch_and_check(int b, logic [31:0] a);
        int snap;
        logic exp_hit;
        exp_hit = m_valid[b][a[7:4]] && (m_tag[b][a[7:4]] == a[31:8]);
        snap = miss_cnt[b];
        @(posedge clk);
        addr_r[b] <= a;
        wait_fetch_result(b, a);
        check_value(sig("hit", b), 128'(exp_hit), 128'(hit_w[b]));
        if (exp_hit) begin
            check_value(sig("cl", b), m_line[b][a[7:4]], cl_w[b]);
        end else begin
            stalled[b] = 1'b1;
            miss_line[b] = {a[31:4], 4'h0};
            check_value("stall", 128'(1), 128'(stall));
        end
        repeat (2) @(negedge clk);
        check_value(sig("alloc_miss count", b), 128'(exp_hit ? 0 : 1), 128'(miss_cnt[b] - snap));
        if (!exp_hit) begin
            check_value(sig("addr_miss", b), 128'(miss_line[b]), 128'(last_miss_addr[b]));
            check_value(sig("op_miss", b), 128'(icache_pkg::OP_RD), 128'(last_miss_op[b]));
        end
        @(posedge clk);
        addr_r[b] <= PARK;
    endtask

    task automatic fill_and_check(int b, logic [31:0] a, logic [31:0] w);
        logic [127:0] line;
        logic [159:0] got;
        line = build_line(w);
        @(posedge clk);
        fill_alloc_r[b] <= 1'b1;
        fill_addr_r[b] <= a;
        fill_line_r[b] <= line;
        @(posedge clk);
        fill_alloc_r[b] <= 1'b0;
        pop_write(b, got);
        check_value(sig("addr_out", b), 128'(a), 128'(got[159:128]));
        check_value(sig("cl", b), line, got[127:0]);
        record_write(b, a, line);
        wait_stall();
    endtask

    task automatic invalidate_and_check(int b, logic [31:0] a);
        logic [159:0] got;
        @(posedge clk);
        inv_alloc_r[b] <= 1'b1;
        inv_addr_r[b] <= a;
        @(posedge clk);
        inv_alloc_r[b] <= 1'b0;
        pop_write(b, got);
        check_value(sig("addr_out", b), 128'(a), 128'(got[159:128]));
        if (m_tag[b][a[7:4]] == a[31:8]) m_valid[b][a[7:4]] = 1'b0;
    endtask

    task automatic hold_miss_and_check(int b, logic [31:0] a);
        int snap;
        snap = miss_cnt[b];
        @(posedge clk);
        fmiss_r[b] <= 1'b1;
        addr_r[b] <= a;
        wait_fetch_result(b, a);
        check_value(sig("hit", b), 128'(0), 128'(hit_w[b]));
        stalled[b] = 1'b1;
        miss_line[b] = {a[31:4], 4'h0};
        @(posedge clk);
        addr_r[b] <= PARK;
        repeat (6) begin
            @(negedge clk);
            check_value("stall", 128'(1), 128'(stall));
        end
        check_value(sig("alloc_miss count", b), 128'(0), 128'(miss_cnt[b] - snap));
        @(posedge clk);
        fmiss_r[b] <= 1'b0;  // Request may leave on the next edge
        repeat (2) @(negedge clk);
        check_value(sig("alloc_miss", b), 128'(1), 128'(allocm_w[b]));
        check_value(sig("addr_miss", b), 128'(miss_line[b]), 128'(amiss_w[b]));
        check_value(sig("op_miss", b), 128'(icache_pkg::OP_RD), 128'(opmiss_w[b]));
        @(negedge clk);
        check_value(sig("alloc_miss count", b), 128'(1), 128'(miss_cnt[b] - snap));
    endtask

    task automatic burst_fill_and_check(int b, logic [31:0] a, logic [31:0] w);
        logic [127:0] lines [Q_LENGTH];
        logic [159:0] got;
        for (int k = 0; k < Q_LENGTH; k++) lines[k] = build_line((w == 0) ? w : w + 32'(k));
        for (int k = 0; k < Q_LENGTH; k++) begin
            @(posedge clk);
            fill_alloc_r[b] <= 1'b1;
            fill_addr_r[b] <= a + 32'(k * 16);
            fill_line_r[b] <= lines[k];
        end
        @(posedge clk);
        fill_alloc_r[b] <= 1'b0;
        for (int k = 0; k < Q_LENGTH; k++) begin  // Must drain in push order
            pop_write(b, got);
            check_value(sig("addr_out", b), 128'(a + 32'(k * 16)), 128'(got[159:128]));
            check_value(sig("cl", b), lines[k], got[127:0]);
            record_write(b, a + 32'(k * 16), lines[k]);
        end
        wait_stall();
    endtask

    task automatic finish_test(int t);
        $display("test %0d finished with %0d errors", t, test_err);
        test_err = 0;
        tests_done++;
    endtask

    task automatic load_vectors();
        int fd, rc, t, b;
        string line_s, act;
        logic [31:0] a, w;
        fd = $fopen("tests/icache_vectors.txt", "r");
        if (fd != 0) begin
            while (!$feof(fd) && n_rec < MAX_REC) begin
                rc = $fgets(line_s, fd);
                if (rc > 0 && line_s.len() > 1 && line_s[0] != 8'h23 &&
                    $sscanf(line_s, "%d %d %s %h %h", t, b, act, a, w) == 5) begin
                    rec_test[n_rec] = t;
                    rec_bank[n_rec] = b;
                    rec_act[n_rec] = act;
                    rec_addr[n_rec] = a;
                    rec_word[n_rec] = w;
                    n_rec++;
                end
            end
            $fclose(fd);
        end
        limit = 40 * n_rec + 16;
    endtask

    initial begin
        for (int b = 0; b < 2; b++) begin
            addr_r[b] <= PARK;
            fill_alloc_r[b] <= 1'b0;
            fill_addr_r[b] <= '0;
            fill_line_r[b] <= '0;
            inv_alloc_r[b] <= 1'b0;
            inv_addr_r[b] <= '0;
            fmiss_r[b] <= 1'b0;
            miss_cnt[b] = 0;
            stalled[b] = 1'b0;
            for (int i = 0; i < 16; i++) m_valid[b][i] = 1'b0;
        end
        load_vectors();
        if (n_rec == 0) begin
            $display("no vector records could be read from tests/icache_vectors.txt");
            $display("=== FAIL ===");
            $finish;
        end else begin
            repeat (8) @(negedge clk);
            check_value("stall", 128'(0), 128'(stall));
            for (int b = 0; b < 2; b++) begin
                check_value(sig("hit", b), 128'(0), 128'(hit_w[b]));
                check_value(sig("alloc_miss", b), 128'(0), 128'(allocm_w[b]));
                check_value(sig("full_fill", b), 128'(0), 128'(ffill_w[b]));
                check_value(sig("full_inv", b), 128'(0), 128'(finv_w[b]));
            end
            @(posedge arst_n);
            for (int b = 0; b < 2; b++) begin  // Both banks miss on the idle line at once
                stalled[b] = 1'b1;
                miss_line[b] = PARK;
            end
            for (int i = 0; i < n_rec; i++) begin
                if (rec_test[i] != cur_test) begin
                    finish_test(cur_test);
                    cur_test = rec_test[i];
                end
                if (rec_act[i] == "fetch") fetch_and_check(rec_bank[i], rec_addr[i]);
                else if (rec_act[i] == "fill")
                    fill_and_check(rec_bank[i], rec_addr[i], rec_word[i]);
                else if (rec_act[i] == "invalidate")
                    invalidate_and_check(rec_bank[i], rec_addr[i]);
                else if (rec_act[i] == "hold") hold_miss_and_check(rec_bank[i], rec_addr[i]);
                else if (rec_act[i] == "push-burst")
                    burst_fill_and_check(rec_bank[i], rec_addr[i], rec_word[i]);
                else begin
                    $display("record %0d has an unknown action %s", i, rec_act[i]);
                    errors++;
                end
            end
            finish_test(cur_test);
            $display("%0d tests, %0d checks, %0d errors", tests_done, checks, errors);
            if (errors == 0) $display("=== PASS ===");
            else $display("=== FAIL ===");
            $finish;
        end
    end

endmodule

//--- tests/icache_vectors.txt
# test bank(0 even, 1 odd) action(fetch fill invalidate hold push-burst) addr(hex)
# line word (hex), 0 gives random line data, otherwise the word is repeated
1 0 fill 0000f000 0
1 1 fill 0000f000 0
2 0 fetch 00012345 0
2 1 fetch 00034567 0
3 0 fill 00012340 0
3 0 fetch 00012348 0
3 1 fill 00034560 a5a5a5a5
3 1 fetch 0003456c 0
4 0 invalidate 00099340 0
4 0 fetch 00012344 0
4 0 invalidate 00012340 0
4 0 fetch 00012344 0
4 0 fill 00012340 0
5 1 hold 00077780 0
5 1 fill 00077780 0
6 0 fetch 000abca0 0
6 0 push-burst 00400010 0
6 0 fill 000abca0 0
6 0 fetch 00400014 0
6 0 fetch 00400084 0
6 0 fetch 000abca8 0

//--- project.f
design/icache_pkg.sv
design/msg_fifo.sv
design/queue_arbitrator.sv
design/cache_bank.sv
design/icache_top.sv
tests/tb_clock.sv
tests/icache_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the icache testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f project.f --top-module icache_tb \
    --Mdir obj_dir -o icache_sim > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "build failed, see build.log"
    exit 1
fi

./obj_dir/icache_sim > sim.log 2>&1
if [ $? -ne 0 ]; then
    echo "simulation exited with an error, see sim.log"
    exit 1
fi

cat sim.log
if grep -q "=== FAIL ===" sim.log; then
    exit 1
fi
exit 0
